//--- Bender.yml
package:
  name: event_unit

sources:
  - include_dirs:
      - src
    files:
      - src/eu_event_pkg.sv
      - src/eu_core_pkg.sv
      - src/sw_event_trigger.sv
      - src/hw_barrier_unit.sv
      - src/event_core_unit.sv
      - src/event_unit_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/event_unit_props.sv
      - tb/tb_event_unit.sv

//--- event_unit.f
+incdir+src
src/eu_event_pkg.sv
src/eu_core_pkg.sv
src/sw_event_trigger.sv
src/hw_barrier_unit.sv
src/event_core_unit.sv
src/event_unit_top.sv
tb/event_unit_props.sv
tb/tb_event_unit.sv

//--- src/eu_core_pkg.sv
// Core side types
`include "eu_macros.svh"

package eu_core_pkg;

  // one bit per core
  typedef logic [`EU_NB_CORES-1:0] core_mask_t;

  // sleep state of a core, clock runs only while active
  typedef enum logic {
    CORE_ACTIVE = 1'b0,
    CORE_SLEEP  = 1'b1
  } core_state_e;

endpackage

//--- src/eu_event_pkg.sv
// Event line types
`include "eu_macros.svh"

package eu_event_pkg;

  // number of a software event
  typedef logic [$clog2(`EU_NB_SW_EVT)-1:0] sw_evt_id_t;

  // software event pulses seen by one core
  typedef logic [`EU_NB_SW_EVT-1:0] sw_evt_vec_t;

  // number of a hardware barrier
  typedef logic [$clog2(`EU_NB_BARR)-1:0] barr_id_t;

  // barrier release pulses seen by one core, bit b from barrier b
  typedef logic [`EU_NB_BARR-1:0] barr_evt_vec_t;

  // external event levels of one core
  typedef logic [`EU_NB_EXT_EVT-1:0] ext_evt_vec_t;

  // full mapped event line, same layout for buffer and mask
  typedef logic [`EU_EVT_W-1:0] evt_line_t;

endpackage

//--- src/eu_macros.svh
// Event unit dimensions
`ifndef EU_MACROS_SVH
`define EU_MACROS_SVH

// number of cores served by the event unit
`define EU_NB_CORES 4

// software events, one line each per core
`define EU_NB_SW_EVT 8

// hardware barriers
`define EU_NB_BARR 4

// external lines per core (accelerator, dma, timer)
`define EU_NB_EXT_EVT 4

// width of the mapped per-core event line
`define EU_EVT_W 16

// bit positions inside the event line
`define EU_SW_EVT_LSB 0
`define EU_BARR_EVT_LSB 8
`define EU_EXT_EVT_LSB 12

`endif

//--- src/event_core_unit.sv
// Per-core event unit
`timescale 1ns/1ps
`include "eu_macros.svh"

module event_core_unit
  import eu_event_pkg::*;
  import eu_core_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,

  // event sources for this core
  input  sw_evt_vec_t   sw_events_i,
  input  barr_evt_vec_t barr_events_i,
  input  ext_evt_vec_t  ext_events_i,

  // event mask register write
  input  logic          evt_mask_we_i,
  input  evt_line_t     evt_mask_i,

  // core asks to wait for an event
  input  logic          wait_req_i,

  output logic          core_clock_en_o,
  output evt_line_t     evt_buffer_o
);

  evt_line_t   evt_line;
  evt_line_t   buffer_q;
  evt_line_t   mask_q;
  evt_line_t   pending;
  evt_line_t   clr_mask;
  core_state_e state_q;
  core_state_e state_d;
  logic        consume;
  logic        clk_en_q;

  // map all sources onto one event line
  always_comb begin
    evt_line = '0;
    evt_line[`EU_SW_EVT_LSB +: `EU_NB_SW_EVT]   = sw_events_i;
    evt_line[`EU_BARR_EVT_LSB +: `EU_NB_BARR]   = barr_events_i;
    evt_line[`EU_EXT_EVT_LSB +: `EU_NB_EXT_EVT] = ext_events_i;
  end

  assign pending = buffer_q & mask_q;

  // sleep machine
  always_comb begin
    state_d = state_q;
    consume = 1'b0;
    case (state_q)
      CORE_ACTIVE: begin
        if (wait_req_i) begin
          // something already pending so the core stays awake
          if (pending != '0) begin
            consume = 1'b1;
          end else begin
            state_d = CORE_SLEEP;
          end
        end
      end
      CORE_SLEEP: begin
        if (pending != '0) begin
          consume = 1'b1;
          state_d = CORE_ACTIVE;
        end
      end
      default: begin
        state_d = CORE_ACTIVE;
      end
    endcase
  end

  // consumed bits are the masked ones that woke the core
  assign clr_mask = consume ? pending : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= CORE_ACTIVE;
      clk_en_q <= 1'b1;
      buffer_q <= '0;
      mask_q   <= '0;
    end else begin
      state_q  <= state_d;
      clk_en_q <= (state_d == CORE_ACTIVE);
      // a new event wins over the clear of the same bit
      buffer_q <= (buffer_q & ~clr_mask) | evt_line;
      if (evt_mask_we_i) begin
        mask_q <= evt_mask_i;
      end
    end
  end

  assign core_clock_en_o = clk_en_q;
  assign evt_buffer_o    = buffer_q;

  // an active core keeps its clock unless it waits with nothing pending
  a_clk_en_when_active : assert property (
    @(posedge clk_i) disable iff (reset_i)
    core_clock_en_o && !(wait_req_i && (pending == '0)) |=> core_clock_en_o
  );

  // a gated core cannot execute the wait instruction
  a_no_wait_while_asleep : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_q == CORE_SLEEP) |-> !wait_req_i
  );

endmodule

//--- src/event_unit_top.sv
// Event unit top level
`timescale 1ns/1ps
`include "eu_macros.svh"

module event_unit_top
  import eu_event_pkg::*;
  import eu_core_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,

  // software event triggers
  input  core_mask_t                          sw_evt_valid_i,
  input  sw_evt_id_t    [`EU_NB_CORES-1:0]    sw_evt_id_i,
  input  core_mask_t    [`EU_NB_CORES-1:0]    sw_evt_mask_i,

  // barrier configuration
  input  logic                                cfg_we_i,
  input  barr_id_t                            cfg_barr_id_i,
  input  core_mask_t                          cfg_part_mask_i,
  input  core_mask_t                          cfg_target_mask_i,

  // barrier arrivals
  input  core_mask_t                          barr_arrive_i,
  input  barr_id_t      [`EU_NB_CORES-1:0]    barr_id_i,

  // per-core inputs
  input  ext_evt_vec_t  [`EU_NB_CORES-1:0]    ext_events_i,
  input  core_mask_t                          evt_mask_we_i,
  input  evt_line_t     [`EU_NB_CORES-1:0]    evt_mask_i,
  input  core_mask_t                          wait_req_i,

  output core_mask_t                          core_clock_en_o,
  output evt_line_t     [`EU_NB_CORES-1:0]    evt_buffer_o
);

  sw_evt_vec_t   [`EU_NB_CORES-1:0] sw_events;
  // release pulses, per barrier and then per core
  core_mask_t    [`EU_NB_BARR-1:0]  barr_release;
  barr_evt_vec_t [`EU_NB_CORES-1:0] barr_events;

  sw_event_trigger sw_event_trigger_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .sw_evt_valid_i ( sw_evt_valid_i ),
    .sw_evt_id_i    ( sw_evt_id_i    ),
    .sw_evt_mask_i  ( sw_evt_mask_i  ),
    .sw_events_o    ( sw_events      )
  );

  for (genvar b = 0; b < `EU_NB_BARR; b++) begin : g_barr
    hw_barrier_unit #(
      .BARR_IDX ( b )
    ) hw_barrier_unit_i (
      .clk_i             ( clk_i             ),
      .reset_i           ( reset_i           ),
      .cfg_we_i          ( cfg_we_i          ),
      .cfg_barr_id_i     ( cfg_barr_id_i     ),
      .cfg_part_mask_i   ( cfg_part_mask_i   ),
      .cfg_target_mask_i ( cfg_target_mask_i ),
      .barr_arrive_i     ( barr_arrive_i     ),
      .barr_id_i         ( barr_id_i         ),
      .barr_event_o      ( barr_release[b]   )
    );
  end

  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : g_core
    // bit b of each core comes from barrier b
    for (genvar b = 0; b < `EU_NB_BARR; b++) begin : g_regroup
      assign barr_events[c][b] = barr_release[b][c];
    end

    event_core_unit event_core_unit_i (
      .clk_i           ( clk_i              ),
      .reset_i         ( reset_i            ),
      .sw_events_i     ( sw_events[c]       ),
      .barr_events_i   ( barr_events[c]     ),
      .ext_events_i    ( ext_events_i[c]    ),
      .evt_mask_we_i   ( evt_mask_we_i[c]   ),
      .evt_mask_i      ( evt_mask_i[c]      ),
      .wait_req_i      ( wait_req_i[c]      ),
      .core_clock_en_o ( core_clock_en_o[c] ),
      .evt_buffer_o    ( evt_buffer_o[c]    )
    );
  end

endmodule

//--- src/hw_barrier_unit.sv
// Hardware barrier
`timescale 1ns/1ps
`include "eu_macros.svh"

module hw_barrier_unit
  import eu_event_pkg::*;
  import eu_core_pkg::*;
#(
  parameter int BARR_IDX = 0
)
(
  input  logic                           clk_i,
  input  logic                           reset_i,

  // configuration write shared by all barriers
  input  logic                           cfg_we_i,
  input  barr_id_t                       cfg_barr_id_i,
  input  core_mask_t                     cfg_part_mask_i,
  input  core_mask_t                     cfg_target_mask_i,

  // arrivals from all cores
  input  core_mask_t                     barr_arrive_i,
  input  barr_id_t   [`EU_NB_CORES-1:0]  barr_id_i,

  // release pulse towards target cores
  output core_mask_t                     barr_event_o
);

  core_mask_t part_mask_q;
  core_mask_t target_mask_q;
  core_mask_t arrived_q;
  core_mask_t arrived_nxt;
  core_mask_t arrive_hit;
  core_mask_t release_q;
  logic       cfg_hit;
  logic       barr_done;

  assign cfg_hit = cfg_we_i && (cfg_barr_id_i == barr_id_t'(BARR_IDX));

  // keep only arrivals addressed to this barrier
  always_comb begin
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      arrive_hit[c] = barr_arrive_i[c] && (barr_id_i[c] == barr_id_t'(BARR_IDX));
    end
  end

  // non-participants are dropped so they cannot block completion
  assign arrived_nxt = arrived_q | (arrive_hit & part_mask_q);

  // an unconfigured barrier never fires
  assign barr_done = (part_mask_q != '0) && (arrived_nxt == part_mask_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      part_mask_q   <= '0;
      target_mask_q <= '0;
      arrived_q     <= '0;
      release_q     <= '0;
    end else begin
      release_q <= '0;
      if (cfg_hit) begin
        // reconfiguration restarts the barrier
        part_mask_q   <= cfg_part_mask_i;
        target_mask_q <= cfg_target_mask_i;
        arrived_q     <= '0;
      end else if (barr_done) begin
        arrived_q <= '0;
        release_q <= target_mask_q;
      end else begin
        arrived_q <= arrived_nxt;
      end
    end
  end

  assign barr_event_o = release_q;

  // arrived stays a proper subset of the participants since a full set is released at once
  a_arrived_in_part : assert property (
    @(posedge clk_i) disable iff (reset_i)
    ((arrived_q & ~part_mask_q) == '0) &&
    ((part_mask_q == '0) || (arrived_q != part_mask_q))
  );

endmodule

//--- src/sw_event_trigger.sv
// Software event trigger
`timescale 1ns/1ps
`include "eu_macros.svh"

module sw_event_trigger
  import eu_event_pkg::*;
  import eu_core_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,

  // one trigger strobe per source core
  input  core_mask_t                          sw_evt_valid_i,
  input  sw_evt_id_t  [`EU_NB_CORES-1:0]      sw_evt_id_i,
  input  core_mask_t  [`EU_NB_CORES-1:0]      sw_evt_mask_i,

  // event pulses per target core
  output sw_evt_vec_t [`EU_NB_CORES-1:0]      sw_events_o
);

  // matrix of target core by event number
  sw_evt_vec_t [`EU_NB_CORES-1:0] evt_matrix_d;
  sw_evt_vec_t [`EU_NB_CORES-1:0] evt_matrix_q;

  // every source may hit any target, results are ORed together
  always_comb begin
    evt_matrix_d = '0;
    for (int src = 0; src < `EU_NB_CORES; src++) begin
      if (sw_evt_valid_i[src]) begin
        for (int tgt = 0; tgt < `EU_NB_CORES; tgt++) begin
          if (sw_evt_mask_i[src][tgt]) begin
            evt_matrix_d[tgt][sw_evt_id_i[src]] = 1'b1;
          end
        end
      end
    end
  end

  // strobes last one cycle, so the registered matrix gives one-cycle pulses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      evt_matrix_q <= '0;
    end else begin
      evt_matrix_q <= evt_matrix_d;
    end
  end

  assign sw_events_o = evt_matrix_q;

endmodule

//--- tb/event_unit_props.sv
// Event unit checker
`timescale 1ns/1ps
`include "eu_macros.svh"

module event_unit_props
  import eu_event_pkg::*;
  import eu_core_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  core_mask_t                       sw_evt_valid_i,
  input  sw_evt_id_t   [`EU_NB_CORES-1:0]  sw_evt_id_i,
  input  core_mask_t   [`EU_NB_CORES-1:0]  sw_evt_mask_i,
  input  logic                             cfg_we_i,
  input  barr_id_t                         cfg_barr_id_i,
  input  core_mask_t                       cfg_part_mask_i,
  input  core_mask_t                       cfg_target_mask_i,
  input  core_mask_t                       barr_arrive_i,
  input  barr_id_t     [`EU_NB_CORES-1:0]  barr_id_i,
  input  ext_evt_vec_t [`EU_NB_CORES-1:0]  ext_events_i,
  input  core_mask_t                       evt_mask_we_i,
  input  evt_line_t    [`EU_NB_CORES-1:0]  evt_mask_i,
  input  core_mask_t                       wait_req_i,
  // DUT outputs under check
  input  core_mask_t                       core_clock_en_i,
  input  evt_line_t    [`EU_NB_CORES-1:0]  evt_buffer_i,
  output int unsigned                      error_count_o
);

  // expected state, built from the event unit rules
  sw_evt_vec_t [`EU_NB_CORES-1:0] exp_sw;
  core_mask_t  [`EU_NB_BARR-1:0]  exp_part;
  core_mask_t  [`EU_NB_BARR-1:0]  exp_targ;
  core_mask_t  [`EU_NB_BARR-1:0]  exp_arr;
  core_mask_t  [`EU_NB_BARR-1:0]  exp_rel;
  evt_line_t   [`EU_NB_CORES-1:0] exp_buf;
  evt_line_t   [`EU_NB_CORES-1:0] exp_mask;
  core_mask_t                     exp_sleep;
  int unsigned                    fail_cnt = 0;

  assign error_count_o = fail_cnt;

  always @(posedge clk_i) begin : ref_model
    sw_evt_vec_t [`EU_NB_CORES-1:0] sw_nxt;
    core_mask_t                     hits;
    evt_line_t                      line;
    evt_line_t                      pend;
    if (reset_i) begin
      exp_sw    <= '0;
      exp_part  <= '0;
      exp_targ  <= '0;
      exp_arr   <= '0;
      exp_rel   <= '0;
      exp_buf   <= '0;
      exp_mask  <= '0;
      exp_sleep <= '0;
    end else begin
      // a strobe with id j reaches bit j of every core in its mask
      sw_nxt = '0;
      for (int s = 0; s < `EU_NB_CORES; s++) begin
        for (int t = 0; t < `EU_NB_CORES; t++) begin
          if (sw_evt_valid_i[s] && sw_evt_mask_i[s][t]) begin
            sw_nxt[t][sw_evt_id_i[s]] = 1'b1;
          end
        end
      end
      exp_sw <= sw_nxt;

      for (int b = 0; b < `EU_NB_BARR; b++) begin
        hits = '0;
        for (int c = 0; c < `EU_NB_CORES; c++) begin
          hits[c] = barr_arrive_i[c] && (barr_id_i[c] == barr_id_t'(b));
        end
        exp_rel[b] <= '0;
        if (cfg_we_i && (cfg_barr_id_i == barr_id_t'(b))) begin
          exp_part[b] <= cfg_part_mask_i;
          exp_targ[b] <= cfg_target_mask_i;
          exp_arr[b]  <= '0;
        end else if (exp_part[b] != '0 &&
                     ((exp_arr[b] | hits) & exp_part[b]) == exp_part[b]) begin
          exp_arr[b] <= '0;
          exp_rel[b] <= exp_targ[b];
        end else begin
          exp_arr[b] <= exp_arr[b] | (hits & exp_part[b]);
        end
      end

      for (int c = 0; c < `EU_NB_CORES; c++) begin
        line = '0;
        line[`EU_SW_EVT_LSB +: `EU_NB_SW_EVT] = exp_sw[c];
        for (int b = 0; b < `EU_NB_BARR; b++) begin
          line[`EU_BARR_EVT_LSB + b] = exp_rel[b][c];
        end
        line[`EU_EXT_EVT_LSB +: `EU_NB_EXT_EVT] = ext_events_i[c];
        pend = exp_buf[c] & exp_mask[c];
        // pending masked bits are consumed on a wait or while asleep
        if (pend != '0 && (exp_sleep[c] || wait_req_i[c])) begin
          exp_buf[c]   <= (exp_buf[c] & ~pend) | line;
          exp_sleep[c] <= 1'b0;
        end else begin
          exp_buf[c] <= exp_buf[c] | line;
          if (wait_req_i[c]) begin
            exp_sleep[c] <= 1'b1;
          end
        end
        if (evt_mask_we_i[c]) begin
          exp_mask[c] <= evt_mask_i[c];
        end
      end
    end
  end

  a_reset_state : assert property (@(posedge clk_i)
    $fell(reset_i) |-> (core_clock_en_i == '1) && (evt_buffer_i == '0))
    else begin
      fail_cnt++;
      $display("ERROR %0t: outputs not in reset state after reset", $time);
    end

  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : g_chk
    a_buffer_match : assert property (@(posedge clk_i) disable iff (reset_i)
      evt_buffer_i[c] == exp_buf[c])
      else begin
        fail_cnt++;
        $display("ERROR %0t: core %0d buffer %h, expected %h", $time, c,
                 $sampled(evt_buffer_i[c]), $sampled(exp_buf[c]));
      end

    a_clock_en_match : assert property (@(posedge clk_i) disable iff (reset_i)
      core_clock_en_i[c] == !exp_sleep[c])
      else begin
        fail_cnt++;
        $display("ERROR %0t: core %0d clock enable %b, expected %b", $time, c,
                 $sampled(core_clock_en_i[c]), !$sampled(exp_sleep[c]));
      end

    // wait with nothing pending gates the clock in the next cycle
    a_sleep_on_wait : assert property (@(posedge clk_i) disable iff (reset_i)
      wait_req_i[c] && ((exp_buf[c] & exp_mask[c]) == '0) |=> !core_clock_en_i[c])
      else begin
        fail_cnt++;
        $display("ERROR %0t: core %0d kept its clock after an idle wait", $time, c);
      end

    a_wake_on_pending : assert property (@(posedge clk_i) disable iff (reset_i)
      (exp_sleep[c] || wait_req_i[c]) && ((exp_buf[c] & exp_mask[c]) != '0)
      |=> core_clock_en_i[c])
      else begin
        fail_cnt++;
        $display("ERROR %0t: core %0d clock off with a masked event pending", $time, c);
      end

    for (genvar k = 0; k < `EU_NB_EXT_EVT; k++) begin : g_ext
      a_ext_to_buffer : assert property (@(posedge clk_i) disable iff (reset_i)
        ext_events_i[c][k] |=> evt_buffer_i[c][`EU_EXT_EVT_LSB + k])
        else begin
          fail_cnt++;
          $display("ERROR %0t: core %0d external line %0d not buffered", $time, c, k);
        end
    end
  end

endmodule

//--- tb/tb_event_unit.sv
// Event unit testbench
`timescale 1ns/1ps
`include "eu_macros.svh"

module tb_event_unit
  import eu_event_pkg::*;
  import eu_core_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int SEED         = 54546;
  localparam int SW_ROUNDS    = 24;

  // cycles used by each test, summed for the watchdog
  localparam int IDLE_CYCLES  = 4;
  localparam int SW_CYCLES    = SW_ROUNDS * 4 + 1;
  localparam int BARR_CYCLES  = `EU_NB_BARR * 24;
  localparam int EXT_CYCLES   = `EU_NB_CORES * `EU_NB_EXT_EVT * 2 + 2;
  localparam int SLEEP_CYCLES = `EU_NB_CORES * 11;
  localparam int PEND_CYCLES  = 4;
  localparam int MARGIN       = 100;
  localparam int WATCHDOG_NS  = CLK_PERIOD * (RESET_CYCLES + IDLE_CYCLES + SW_CYCLES
    + BARR_CYCLES + EXT_CYCLES + SLEEP_CYCLES + PEND_CYCLES + MARGIN);

  logic                             clk;
  logic                             reset;
  core_mask_t                       sw_evt_valid;
  sw_evt_id_t   [`EU_NB_CORES-1:0]  sw_evt_id;
  core_mask_t   [`EU_NB_CORES-1:0]  sw_evt_mask;
  logic                             cfg_we;
  barr_id_t                         cfg_barr_id;
  core_mask_t                       cfg_part_mask;
  core_mask_t                       cfg_target_mask;
  core_mask_t                       barr_arrive;
  barr_id_t     [`EU_NB_CORES-1:0]  barr_id;
  ext_evt_vec_t [`EU_NB_CORES-1:0]  ext_events;
  core_mask_t                       evt_mask_we;
  evt_line_t    [`EU_NB_CORES-1:0]  evt_mask;
  core_mask_t                       wait_req;
  core_mask_t                       core_clock_en;
  evt_line_t    [`EU_NB_CORES-1:0]  evt_buffer;
  int unsigned                      error_count;
  int unsigned                      err_at_start;
  int unsigned                      tests_run;
  int unsigned                      tests_failed;

  event_unit_top dut_i (
    .clk_i             ( clk             ),
    .reset_i           ( reset           ),
    .sw_evt_valid_i    ( sw_evt_valid    ),
    .sw_evt_id_i       ( sw_evt_id       ),
    .sw_evt_mask_i     ( sw_evt_mask     ),
    .cfg_we_i          ( cfg_we          ),
    .cfg_barr_id_i     ( cfg_barr_id     ),
    .cfg_part_mask_i   ( cfg_part_mask   ),
    .cfg_target_mask_i ( cfg_target_mask ),
    .barr_arrive_i     ( barr_arrive     ),
    .barr_id_i         ( barr_id         ),
    .ext_events_i      ( ext_events      ),
    .evt_mask_we_i     ( evt_mask_we     ),
    .evt_mask_i        ( evt_mask        ),
    .wait_req_i        ( wait_req        ),
    .core_clock_en_o   ( core_clock_en   ),
    .evt_buffer_o      ( evt_buffer      )
  );

  event_unit_props props_i (
    .clk_i             ( clk             ),
    .reset_i           ( reset           ),
    .sw_evt_valid_i    ( sw_evt_valid    ),
    .sw_evt_id_i       ( sw_evt_id       ),
    .sw_evt_mask_i     ( sw_evt_mask     ),
    .cfg_we_i          ( cfg_we          ),
    .cfg_barr_id_i     ( cfg_barr_id     ),
    .cfg_part_mask_i   ( cfg_part_mask   ),
    .cfg_target_mask_i ( cfg_target_mask ),
    .barr_arrive_i     ( barr_arrive     ),
    .barr_id_i         ( barr_id         ),
    .ext_events_i      ( ext_events      ),
    .evt_mask_we_i     ( evt_mask_we     ),
    .evt_mask_i        ( evt_mask        ),
    .wait_req_i        ( wait_req        ),
    .core_clock_en_i   ( core_clock_en   ),
    .evt_buffer_i      ( evt_buffer      ),
    .error_count_o     ( error_count     )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns, stopping", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    int unsigned new_err;
    new_err = error_count - err_at_start;
    tests_run++;
    if (new_err != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d assertion failures", tests_run, name,
             (new_err == 0) ? "ok" : "failed", new_err);
    err_at_start = error_count;
  endtask

  task automatic send_sw_event(input int src, input int id, input core_mask_t mask);
    sw_evt_valid[src] = 1'b1;
    sw_evt_id[src]    = sw_evt_id_t'(id);
    sw_evt_mask[src]  = mask;
    cycles(1);
    sw_evt_valid = '0;
  endtask

  task automatic set_all_masks();
    evt_mask_we = '1;
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      evt_mask[c] = '1;
    end
  endtask

  task automatic run_sw_events();
    core_mask_t hit;
    // every bit watched, so each round drains what it delivered
    set_all_masks();
    cycles(1);
    evt_mask_we = '0;
    for (int r = 0; r < SW_ROUNDS; r++) begin
      hit = '0;
      for (int c = 0; c < `EU_NB_CORES; c++) begin
        sw_evt_valid[c] = ($urandom_range(0, 2) != 0);
        sw_evt_id[c]    = sw_evt_id_t'($urandom_range(0, `EU_NB_SW_EVT - 1));
        sw_evt_mask[c]  = core_mask_t'($urandom);
        if (sw_evt_valid[c]) begin
          hit = hit | sw_evt_mask[c];
        end
      end
      cycles(1);
      sw_evt_valid = '0;
      cycles(1);
      wait_req = hit;
      cycles(1);
      wait_req = '0;
      cycles(1);
    end
  endtask

  task automatic barrier_round(input int b, input core_mask_t part, input core_mask_t targ,
                               input logic together);
    if (together) begin
      barr_arrive = part;
      for (int c = 0; c < `EU_NB_CORES; c++) begin
        barr_id[c] = barr_id_t'(b);
      end
      cycles(1);
      barr_arrive = '0;
      cycles(1);
    end else begin
      for (int c = 0; c < `EU_NB_CORES; c++) begin
        if (part[c]) begin
          barr_arrive[c] = 1'b1;
          barr_id[c]     = barr_id_t'(b);
          cycles(1);
          barr_arrive = '0;
          cycles(1);
        end
      end
    end
    // release is buffered now, targets consume it
    wait_req = targ;
    cycles(1);
    wait_req = '0;
    cycles(1);
  endtask

  task automatic run_barriers();
    core_mask_t part;
    core_mask_t targ;
    for (int b = 0; b < `EU_NB_BARR; b++) begin
      part            = core_mask_t'($urandom_range(1, (1 << `EU_NB_CORES) - 1));
      targ            = core_mask_t'($urandom_range(1, (1 << `EU_NB_CORES) - 1));
      cfg_we          = 1'b1;
      cfg_barr_id     = barr_id_t'(b);
      cfg_part_mask   = part;
      cfg_target_mask = targ;
      cycles(1);
      cfg_we = 1'b0;
      barrier_round(b, part, targ, 1'b0);
      // second round reuses the configuration
      barrier_round(b, part, targ, 1'b1);
    end
  endtask

  task automatic run_ext_events();
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      for (int k = 0; k < `EU_NB_EXT_EVT; k++) begin
        ext_events[c][k] = 1'b1;
        cycles(1);
        ext_events[c][k] = 1'b0;
        cycles(1);
      end
    end
    wait_req = '1;
    cycles(1);
    wait_req = '0;
    cycles(1);
  endtask

  task automatic sleep_and_wake(input int c);
    int j;
    int src;
    j   = $urandom_range(0, `EU_NB_SW_EVT - 1);
    src = (c + 1) % `EU_NB_CORES;
    evt_mask_we[c] = 1'b1;
    evt_mask[c]    = evt_line_t'(1) << (`EU_SW_EVT_LSB + j);
    cycles(1);
    evt_mask_we[c] = 1'b0;
    // empty buffer, so this wait puts the core to sleep
    wait_req[c] = 1'b1;
    cycles(1);
    wait_req[c] = 1'b0;
    send_sw_event(src, (j + 1) % `EU_NB_SW_EVT, core_mask_t'(1) << c);
    cycles(3);
    send_sw_event(src, j, core_mask_t'(1) << c);
    cycles(4);
  endtask

  task automatic run_pending_wait();
    set_all_masks();
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      ext_events[c] = ext_evt_vec_t'(1);
    end
    cycles(1);
    evt_mask_we = '0;
    ext_events  = '0;
    // masked event already buffered, no core may sleep
    wait_req = '1;
    cycles(1);
    wait_req = '0;
    cycles(2);
  endtask

  initial begin
    void'($urandom(SEED));
    err_at_start    = 0;
    tests_run       = 0;
    tests_failed    = 0;
    reset           = 1'b1;
    sw_evt_valid    = '0;
    sw_evt_id       = '0;
    sw_evt_mask     = '0;
    cfg_we          = 1'b0;
    cfg_barr_id     = '0;
    cfg_part_mask   = '0;
    cfg_target_mask = '0;
    barr_arrive     = '0;
    barr_id         = '0;
    ext_events      = '0;
    evt_mask_we     = '0;
    evt_mask        = '0;
    wait_req        = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    cycles(IDLE_CYCLES);
    finish_test("reset state");
    run_sw_events();
    finish_test("software events");
    run_barriers();
    finish_test("hardware barriers");
    run_ext_events();
    finish_test("external lines");
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      sleep_and_wake(c);
    end
    finish_test("sleep and wake");
    run_pending_wait();
    finish_test("wait with pending event");

    $display("summary: %0d tests, %0d failed, %0d assertion failures",
             tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
